/* hw/mips_control_macros.svh */
`ifndef MIPS_CONTROL_MACROS_SVH
`define MIPS_CONTROL_MACROS_SVH

// Instruction fields
`define MC_INSTR_WIDTH     32
`define MC_OPCODE_WIDTH    6
`define MC_FUNCT_WIDTH     6
`define MC_REG_WIDTH       5
`define MC_SHAMT_WIDTH     5

// Control word fields
`define MC_ALU_OP_WIDTH    2
`define MC_ALU_CTRL_WIDTH  4
`define MC_MEM_SEL_WIDTH   3   // Sign bit plus two-bit size

`endif

/* hw/mips_control_pkg.sv */
`include "mips_control_macros.svh"

package mips_control_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Instruction view
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed
   {
      logic [`MC_OPCODE_WIDTH-1:0] opcode;
      logic [`MC_REG_WIDTH-1:0]    rs;
      logic [`MC_REG_WIDTH-1:0]    rt;
      logic [`MC_REG_WIDTH-1:0]    rd;     // Low immediate bits outside R-type
      logic [`MC_SHAMT_WIDTH-1:0]  shamt;
      logic [`MC_FUNCT_WIDTH-1:0]  funct;
   } instr_t;

   typedef enum logic [`MC_OPCODE_WIDTH-1:0]
   {
      OP_SPECIAL = 6'd0,   // R-type, decoded by funct
      OP_J       = 6'd2,
      OP_JAL     = 6'd3,
      OP_BEQ     = 6'd4,
      OP_BNE     = 6'd5,
      OP_ADDI    = 6'd8,
      OP_SLTI    = 6'd10,
      OP_ANDI    = 6'd12,
      OP_ORI     = 6'd13,
      OP_XORI    = 6'd14,
      OP_LUI     = 6'd15,
      OP_LB      = 6'd32,
      OP_LH      = 6'd33,
      OP_LW      = 6'd35,
      OP_LBU     = 6'd36,
      OP_LHU     = 6'd37,
      OP_LWU     = 6'd39,
      OP_SB      = 6'd40,
      OP_SH      = 6'd41,
      OP_SW      = 6'd43
   } opcode_e;

   typedef enum logic [`MC_FUNCT_WIDTH-1:0]
   {
      F_SLL  = 6'd0,
      F_SRL  = 6'd2,
      F_SRA  = 6'd3,
      F_SLLV = 6'd4,
      F_SRLV = 6'd6,
      F_SRAV = 6'd7,
      F_JR   = 6'd8,
      F_JALR = 6'd9,
      F_ADDU = 6'd33,
      F_SUBU = 6'd35,
      F_AND  = 6'd36,
      F_OR   = 6'd37,
      F_XOR  = 6'd38,
      F_NOR  = 6'd39,
      F_SLT  = 6'd42
   } funct_e;

   ////////////////////////////////////////////////////////////////////////////
   // Control word
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [`MC_ALU_OP_WIDTH-1:0]
   {
      ALU_OP_MEM    = 2'd0,   // Also LUI and unknown codes
      ALU_OP_BRANCH = 2'd1,
      ALU_OP_ARITH  = 2'd2
   } alu_op_e;

   typedef enum logic [`MC_ALU_CTRL_WIDTH-1:0]
   {
      ALU_CTRL_AND  = 4'd0,
      ALU_CTRL_OR   = 4'd1,
      ALU_CTRL_ADD  = 4'd2,
      ALU_CTRL_SUB  = 4'd6,
      ALU_CTRL_SLT  = 4'd7,
      ALU_CTRL_LUI  = 4'd8,
      ALU_CTRL_XOR  = 4'd9,
      ALU_CTRL_NOR  = 4'd10,
      ALU_CTRL_SLL  = 4'd11,
      ALU_CTRL_SRL  = 4'd12,
      ALU_CTRL_SRA  = 4'd13,
      ALU_CTRL_JUMP = 4'd14
   } alu_ctrl_e;

   typedef enum logic [`MC_MEM_SEL_WIDTH-2:0]
   {
      MEM_SIZE_NONE = 2'd0,
      MEM_SIZE_BYTE = 2'd1,
      MEM_SIZE_HALF = 2'd2,
      MEM_SIZE_WORD = 2'd3
   } mem_size_e;

   typedef struct packed
   {
      logic      is_signed;   // Sign-extend loaded data
      mem_size_e size;
   } mem_sel_t;

   typedef struct packed
   {
      logic     reg_dst;
      logic     reg_write;
      logic     alu_src;
      logic     mem_read;
      logic     mem_write;
      logic     mem_to_reg;
      mem_sel_t mem_sel;
   } main_ctrl_t;

   typedef struct packed
   {
      main_ctrl_t main;
      alu_op_e    alu_op;
      alu_ctrl_e  alu_ctrl;
   } ctrl_word_t;

endpackage

/* hw/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder
(
   input  mips_control_pkg::instr_t     i_instruction,
   output mips_control_pkg::main_ctrl_t o_main_ctrl,
   output mips_control_pkg::alu_op_e    o_alu_op
);

   mips_control_pkg::main_ctrl_t main_ctrl;
   mips_control_pkg::alu_op_e    alu_op;
   mips_control_pkg::mem_sel_t   mem_sel;

   /////////////////////////////////////////////////////////////////////////////
   // Memory access select, only loads and stores carry a size
   /////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      mem_sel.is_signed = 1'b0;
      mem_sel.size      = mips_control_pkg::MEM_SIZE_NONE;
      case (i_instruction.opcode)
         mips_control_pkg::OP_LB:
         begin
            mem_sel.is_signed = 1'b1;
            mem_sel.size      = mips_control_pkg::MEM_SIZE_BYTE;
         end
         mips_control_pkg::OP_LH:
         begin
            mem_sel.is_signed = 1'b1;
            mem_sel.size      = mips_control_pkg::MEM_SIZE_HALF;
         end
         mips_control_pkg::OP_LW:
         begin
            mem_sel.is_signed = 1'b1;
            mem_sel.size      = mips_control_pkg::MEM_SIZE_WORD;
         end
         mips_control_pkg::OP_LBU, mips_control_pkg::OP_SB:
         begin
            mem_sel.size = mips_control_pkg::MEM_SIZE_BYTE;
         end
         mips_control_pkg::OP_LHU, mips_control_pkg::OP_SH:
         begin
            mem_sel.size = mips_control_pkg::MEM_SIZE_HALF;
         end
         mips_control_pkg::OP_LWU, mips_control_pkg::OP_SW:
         begin
            mem_sel.size = mips_control_pkg::MEM_SIZE_WORD;
         end
         default:
         begin
            mem_sel.size = mips_control_pkg::MEM_SIZE_NONE;
         end
      endcase
   end

   /////////////////////////////////////////////////////////////////////////////
   // Main controls and operation class
   /////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      main_ctrl         = '0;
      alu_op            = mips_control_pkg::ALU_OP_MEM;   // Unknown codes stay here
      main_ctrl.mem_sel = mem_sel;
      if (i_instruction.opcode == mips_control_pkg::OP_SPECIAL)
      begin
         case (i_instruction.funct)
            mips_control_pkg::F_SLL, mips_control_pkg::F_SRL, mips_control_pkg::F_SRA:
            begin
               main_ctrl.reg_dst   = 1'b1;
               main_ctrl.reg_write = 1'b1;
               main_ctrl.alu_src   = 1'b1;                // Shift amount from shamt
               alu_op              = mips_control_pkg::ALU_OP_ARITH;
            end
            mips_control_pkg::F_SLLV, mips_control_pkg::F_SRLV, mips_control_pkg::F_SRAV,
            mips_control_pkg::F_ADDU, mips_control_pkg::F_SUBU, mips_control_pkg::F_AND,
            mips_control_pkg::F_OR, mips_control_pkg::F_XOR, mips_control_pkg::F_NOR,
            mips_control_pkg::F_SLT:
            begin
               main_ctrl.reg_dst   = 1'b1;
               main_ctrl.reg_write = 1'b1;
               alu_op              = mips_control_pkg::ALU_OP_ARITH;
            end
            mips_control_pkg::F_JALR:
            begin
               main_ctrl.reg_dst   = 1'b1;
               main_ctrl.reg_write = 1'b1;                // Link into rd
               alu_op              = mips_control_pkg::ALU_OP_BRANCH;
            end
            mips_control_pkg::F_JR:
            begin
               alu_op = mips_control_pkg::ALU_OP_BRANCH;
            end
            default:
            begin
               alu_op = mips_control_pkg::ALU_OP_MEM;
            end
         endcase
      end
      else
      begin
         case (i_instruction.opcode)
            mips_control_pkg::OP_LB, mips_control_pkg::OP_LH, mips_control_pkg::OP_LW,
            mips_control_pkg::OP_LBU, mips_control_pkg::OP_LHU, mips_control_pkg::OP_LWU:
            begin
               main_ctrl.reg_write  = 1'b1;
               main_ctrl.alu_src    = 1'b1;
               main_ctrl.mem_read   = 1'b1;
               main_ctrl.mem_to_reg = 1'b1;
            end
            mips_control_pkg::OP_SB, mips_control_pkg::OP_SH, mips_control_pkg::OP_SW:
            begin
               main_ctrl.alu_src   = 1'b1;
               main_ctrl.mem_write = 1'b1;
            end
            mips_control_pkg::OP_ADDI, mips_control_pkg::OP_ANDI, mips_control_pkg::OP_ORI,
            mips_control_pkg::OP_XORI, mips_control_pkg::OP_SLTI:
            begin
               main_ctrl.reg_write = 1'b1;
               main_ctrl.alu_src   = 1'b1;
               alu_op              = mips_control_pkg::ALU_OP_ARITH;
            end
            mips_control_pkg::OP_LUI:
            begin
               main_ctrl.reg_write = 1'b1;
               main_ctrl.alu_src   = 1'b1;                // Class stays MEM
            end
            mips_control_pkg::OP_BEQ, mips_control_pkg::OP_BNE:
            begin
               main_ctrl.alu_src = 1'b1;
               alu_op            = mips_control_pkg::ALU_OP_BRANCH;
            end
            mips_control_pkg::OP_JAL:
            begin
               main_ctrl.reg_write = 1'b1;                // Return address to r31
               alu_op              = mips_control_pkg::ALU_OP_BRANCH;
            end
            mips_control_pkg::OP_J:
            begin
               alu_op = mips_control_pkg::ALU_OP_BRANCH;
            end
            default:
            begin
               alu_op = mips_control_pkg::ALU_OP_MEM;
            end
         endcase
      end
   end

   assign o_main_ctrl = main_ctrl;
   assign o_alu_op    = alu_op;

endmodule

/* hw/alu_control_stage.sv */
`timescale 1ns/1ps

module alu_control_stage
(
   input  logic                         i_clock,
   input  logic                         i_soft_reset,
   input  logic                         i_enable,
   input  mips_control_pkg::instr_t     i_instruction,
   input  mips_control_pkg::main_ctrl_t i_main_ctrl,
   input  mips_control_pkg::alu_op_e    i_alu_op,
   output mips_control_pkg::ctrl_word_t o_ctrl
);

   mips_control_pkg::alu_ctrl_e  alu_ctrl_next;
   mips_control_pkg::ctrl_word_t ctrl_next;
   mips_control_pkg::ctrl_word_t ctrl_q;

   /////////////////////////////////////////////////////////////////////////////
   // ALU control code from the same instruction as the class
   /////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      alu_ctrl_next = mips_control_pkg::ALU_CTRL_ADD;
      case (i_alu_op)
         mips_control_pkg::ALU_OP_MEM:
         begin
            if (i_instruction.opcode == mips_control_pkg::OP_LUI)
            begin
               alu_ctrl_next = mips_control_pkg::ALU_CTRL_LUI;
            end
            else
            begin
               alu_ctrl_next = mips_control_pkg::ALU_CTRL_ADD;   // Address calculation
            end
         end
         mips_control_pkg::ALU_OP_BRANCH:
         begin
            alu_ctrl_next = mips_control_pkg::ALU_CTRL_JUMP;
         end
         mips_control_pkg::ALU_OP_ARITH:
         begin
            if (i_instruction.opcode == mips_control_pkg::OP_SPECIAL)
            begin
               case (i_instruction.funct)
                  mips_control_pkg::F_SLL, mips_control_pkg::F_SLLV:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_SLL;
                  mips_control_pkg::F_SRL, mips_control_pkg::F_SRLV:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_SRL;
                  mips_control_pkg::F_SRA, mips_control_pkg::F_SRAV:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_SRA;
                  mips_control_pkg::F_ADDU:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_ADD;
                  mips_control_pkg::F_SUBU:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_SUB;
                  mips_control_pkg::F_AND:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_AND;
                  mips_control_pkg::F_OR:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_OR;
                  mips_control_pkg::F_XOR:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_XOR;
                  mips_control_pkg::F_NOR:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_NOR;
                  mips_control_pkg::F_SLT:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_SLT;
                  default:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_ADD;
               endcase
            end
            else
            begin
               case (i_instruction.opcode)                          // Immediate forms
                  mips_control_pkg::OP_ADDI:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_ADD;
                  mips_control_pkg::OP_ANDI:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_AND;
                  mips_control_pkg::OP_ORI:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_OR;
                  mips_control_pkg::OP_XORI:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_XOR;
                  mips_control_pkg::OP_SLTI:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_SLT;
                  default:
                     alu_ctrl_next = mips_control_pkg::ALU_CTRL_ADD;
               endcase
            end
         end
         default:
         begin
            alu_ctrl_next = mips_control_pkg::ALU_CTRL_ADD;
         end
      endcase
   end

   always_comb
   begin
      ctrl_next.main     = i_main_ctrl;
      ctrl_next.alu_op   = i_alu_op;
      ctrl_next.alu_ctrl = alu_ctrl_next;
   end

   /////////////////////////////////////////////////////////////////////////////
   // Control word register
   /////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clock)
   begin
      if (!i_soft_reset)
      begin
         ctrl_q <= '0;                                              // All controls inactive
      end
      else if (i_enable)
      begin
         ctrl_q <= ctrl_next;
      end
   end

   assign o_ctrl = ctrl_q;

   // Decoder never asks for a read and a write together
   a_no_read_and_write : assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      !(o_ctrl.main.mem_read && o_ctrl.main.mem_write));

   a_to_reg_needs_read : assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      o_ctrl.main.mem_to_reg |-> o_ctrl.main.mem_read);

   a_hold_on_stall : assert property (@(posedge i_clock) disable iff (!i_soft_reset)
      !i_enable |=> $stable(o_ctrl));

endmodule

/* hw/mips_control.sv */
`timescale 1ns/1ps

module mips_control
(
   input  logic                         i_clock,
   input  logic                         i_soft_reset,
   input  logic                         i_enable,
   input  mips_control_pkg::instr_t     i_instruction,
   output mips_control_pkg::ctrl_word_t o_ctrl
);

   mips_control_pkg::main_ctrl_t main_ctrl;   // Decoded this cycle
   mips_control_pkg::alu_op_e    alu_op;

   main_decoder main_decoder_inst
   (
      .i_instruction (i_instruction),
      .o_main_ctrl   (main_ctrl),
      .o_alu_op      (alu_op)
   );

   alu_control_stage alu_control_stage_inst
   (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_enable      (i_enable),
      .i_instruction (i_instruction),
      .i_main_ctrl   (main_ctrl),
      .i_alu_op      (alu_op),
      .o_ctrl        (o_ctrl)
   );

endmodule

/* bench/mips_control_tests.svh */
// Operation classes and ALU codes as numbers
localparam logic [1:0] K_MEM    = 2'd0;
localparam logic [1:0] K_BRANCH = 2'd1;
localparam logic [1:0] K_ARITH  = 2'd2;
localparam logic [3:0] C_AND  = 4'd0;
localparam logic [3:0] C_OR   = 4'd1;
localparam logic [3:0] C_ADD  = 4'd2;
localparam logic [3:0] C_SUB  = 4'd6;
localparam logic [3:0] C_SLT  = 4'd7;
localparam logic [3:0] C_LUI  = 4'd8;
localparam logic [3:0] C_XOR  = 4'd9;
localparam logic [3:0] C_NOR  = 4'd10;
localparam logic [3:0] C_SLL  = 4'd11;
localparam logic [3:0] C_SRL  = 4'd12;
localparam logic [3:0] C_SRA  = 4'd13;
localparam logic [3:0] C_JUMP = 4'd14;

localparam mips_control_pkg::funct_e R_FUNCTS [15] = '{
   mips_control_pkg::F_SLL, mips_control_pkg::F_SRL, mips_control_pkg::F_SRA,
   mips_control_pkg::F_SLLV, mips_control_pkg::F_SRLV, mips_control_pkg::F_SRAV,
   mips_control_pkg::F_ADDU, mips_control_pkg::F_SUBU, mips_control_pkg::F_AND,
   mips_control_pkg::F_OR, mips_control_pkg::F_XOR, mips_control_pkg::F_NOR,
   mips_control_pkg::F_SLT, mips_control_pkg::F_JR, mips_control_pkg::F_JALR};
localparam mips_control_pkg::opcode_e M_OPS [9] = '{
   mips_control_pkg::OP_LB, mips_control_pkg::OP_LH, mips_control_pkg::OP_LW,
   mips_control_pkg::OP_LWU, mips_control_pkg::OP_LBU, mips_control_pkg::OP_LHU,
   mips_control_pkg::OP_SB, mips_control_pkg::OP_SH, mips_control_pkg::OP_SW};
localparam mips_control_pkg::opcode_e I_OPS [10] = '{
   mips_control_pkg::OP_ADDI, mips_control_pkg::OP_ANDI, mips_control_pkg::OP_ORI,
   mips_control_pkg::OP_XORI, mips_control_pkg::OP_SLTI, mips_control_pkg::OP_LUI,
   mips_control_pkg::OP_BEQ, mips_control_pkg::OP_BNE, mips_control_pkg::OP_J,
   mips_control_pkg::OP_JAL};

////////////////////////////////////////////////////////////////////////////
// Reference model from the decode tables
////////////////////////////////////////////////////////////////////////////

// Flags are reg_dst, reg_write, alu_src, mem_read, mem_write, mem_to_reg
function automatic mips_control_pkg::ctrl_word_t pack_word(input logic [5:0] flags,
   input logic [2:0] mem_sel, input logic [1:0] alu_op, input logic [3:0] alu_ctrl);
   mips_control_pkg::ctrl_word_t w;
   w = {flags, mem_sel, alu_op, alu_ctrl};
   return w;
endfunction

function automatic mips_control_pkg::ctrl_word_t expected_ctrl(
   input mips_control_pkg::instr_t instr);
   mips_control_pkg::ctrl_word_t w;
   if (instr.opcode == 6'd0)
   begin
      case (instr.funct)
         mips_control_pkg::F_SLL:  w = pack_word(6'b111000, 3'd0, K_ARITH, C_SLL);
         mips_control_pkg::F_SRL:  w = pack_word(6'b111000, 3'd0, K_ARITH, C_SRL);
         mips_control_pkg::F_SRA:  w = pack_word(6'b111000, 3'd0, K_ARITH, C_SRA);
         mips_control_pkg::F_SLLV: w = pack_word(6'b110000, 3'd0, K_ARITH, C_SLL);
         mips_control_pkg::F_SRLV: w = pack_word(6'b110000, 3'd0, K_ARITH, C_SRL);
         mips_control_pkg::F_SRAV: w = pack_word(6'b110000, 3'd0, K_ARITH, C_SRA);
         mips_control_pkg::F_ADDU: w = pack_word(6'b110000, 3'd0, K_ARITH, C_ADD);
         mips_control_pkg::F_SUBU: w = pack_word(6'b110000, 3'd0, K_ARITH, C_SUB);
         mips_control_pkg::F_AND:  w = pack_word(6'b110000, 3'd0, K_ARITH, C_AND);
         mips_control_pkg::F_OR:   w = pack_word(6'b110000, 3'd0, K_ARITH, C_OR);
         mips_control_pkg::F_XOR:  w = pack_word(6'b110000, 3'd0, K_ARITH, C_XOR);
         mips_control_pkg::F_NOR:  w = pack_word(6'b110000, 3'd0, K_ARITH, C_NOR);
         mips_control_pkg::F_SLT:  w = pack_word(6'b110000, 3'd0, K_ARITH, C_SLT);
         mips_control_pkg::F_JALR: w = pack_word(6'b110000, 3'd0, K_BRANCH, C_JUMP);
         mips_control_pkg::F_JR:   w = pack_word(6'b000000, 3'd0, K_BRANCH, C_JUMP);
         default:                  w = pack_word(6'b000000, 3'd0, K_MEM, C_ADD);
      endcase
   end
   else
   begin
      case (instr.opcode)
         mips_control_pkg::OP_LB:   w = pack_word(6'b011101, 3'd5, K_MEM, C_ADD);
         mips_control_pkg::OP_LH:   w = pack_word(6'b011101, 3'd6, K_MEM, C_ADD);
         mips_control_pkg::OP_LW:   w = pack_word(6'b011101, 3'd7, K_MEM, C_ADD);
         mips_control_pkg::OP_LWU:  w = pack_word(6'b011101, 3'd3, K_MEM, C_ADD);
         mips_control_pkg::OP_LBU:  w = pack_word(6'b011101, 3'd1, K_MEM, C_ADD);
         mips_control_pkg::OP_LHU:  w = pack_word(6'b011101, 3'd2, K_MEM, C_ADD);
         mips_control_pkg::OP_SB:   w = pack_word(6'b001010, 3'd1, K_MEM, C_ADD);
         mips_control_pkg::OP_SH:   w = pack_word(6'b001010, 3'd2, K_MEM, C_ADD);
         mips_control_pkg::OP_SW:   w = pack_word(6'b001010, 3'd3, K_MEM, C_ADD);
         mips_control_pkg::OP_ADDI: w = pack_word(6'b011000, 3'd0, K_ARITH, C_ADD);
         mips_control_pkg::OP_ANDI: w = pack_word(6'b011000, 3'd0, K_ARITH, C_AND);
         mips_control_pkg::OP_ORI:  w = pack_word(6'b011000, 3'd0, K_ARITH, C_OR);
         mips_control_pkg::OP_XORI: w = pack_word(6'b011000, 3'd0, K_ARITH, C_XOR);
         mips_control_pkg::OP_SLTI: w = pack_word(6'b011000, 3'd0, K_ARITH, C_SLT);
         mips_control_pkg::OP_LUI:  w = pack_word(6'b011000, 3'd0, K_MEM, C_LUI);
         mips_control_pkg::OP_BEQ:  w = pack_word(6'b001000, 3'd0, K_BRANCH, C_JUMP);
         mips_control_pkg::OP_BNE:  w = pack_word(6'b001000, 3'd0, K_BRANCH, C_JUMP);
         mips_control_pkg::OP_J:    w = pack_word(6'b000000, 3'd0, K_BRANCH, C_JUMP);
         mips_control_pkg::OP_JAL:  w = pack_word(6'b010000, 3'd0, K_BRANCH, C_JUMP);
         default:                   w = pack_word(6'b000000, 3'd0, K_MEM, C_ADD);
      endcase
   end
   return w;
endfunction

////////////////////////////////////////////////////////////////////////////
// Stimulus helpers
////////////////////////////////////////////////////////////////////////////

function automatic mips_control_pkg::instr_t rand_instr();
   mips_control_pkg::instr_t instr;
   instr = $urandom();
   return instr;
endfunction

function automatic mips_control_pkg::instr_t r_instr(input logic [5:0] funct);
   mips_control_pkg::instr_t instr;
   instr        = rand_instr();   // Random rs, rt, rd and shamt
   instr.opcode = 6'd0;
   instr.funct  = funct;
   return instr;
endfunction

function automatic mips_control_pkg::instr_t op_instr(input logic [5:0] opcode);
   mips_control_pkg::instr_t instr;
   instr        = rand_instr();
   instr.opcode = opcode;
   return instr;
endfunction

function automatic logic opcode_listed(input logic [5:0] code);
   logic found;
   found = (code == 6'd0);
   for (int k = 0; k < 9; k++)
      found = found | (code == M_OPS[k]);
   for (int k = 0; k < 10; k++)
      found = found | (code == I_OPS[k]);
   return found;
endfunction

function automatic logic funct_listed(input logic [5:0] code);
   logic found;
   found = 1'b0;
   for (int k = 0; k < 15; k++)
      found = found | (code == R_FUNCTS[k]);
   return found;
endfunction

// One enabled edge and a check of the registered word
task automatic run_and_check(input mips_control_pkg::instr_t instr);
   @(posedge i_clock);
   i_instruction <= instr;
   i_enable      <= 1'b1;
   @(posedge i_clock);
   i_enable <= 1'b0;
   @(negedge i_clock);
   current_instr = instr;
   check_ctrl("o_ctrl", o_ctrl, expected_ctrl(instr));
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic reset_clears_word();
   @(negedge i_clock);
   check_ctrl("o_ctrl after reset", o_ctrl, '0);
   check_alu_ctrl("o_ctrl.alu_ctrl after reset", o_ctrl.alu_ctrl, mips_control_pkg::ALU_CTRL_AND);
endtask

task automatic r_type_decode();
   for (int k = 0; k < 15; k++)
      run_and_check(r_instr(R_FUNCTS[k]));
endtask

task automatic loads_and_stores();
   for (int k = 0; k < 9; k++)
      run_and_check(op_instr(M_OPS[k]));
endtask

task automatic immediates_and_jumps();
   for (int k = 0; k < 10; k++)
      run_and_check(op_instr(I_OPS[k]));
   run_and_check(op_instr(mips_control_pkg::OP_LUI));   // MEM class path
   check_alu_ctrl("o_ctrl.alu_ctrl", o_ctrl.alu_ctrl, mips_control_pkg::ALU_CTRL_LUI);
   run_and_check(op_instr(mips_control_pkg::OP_J));
   check_alu_ctrl("o_ctrl.alu_ctrl", o_ctrl.alu_ctrl, mips_control_pkg::ALU_CTRL_JUMP);
endtask

task automatic unknown_codes();
   logic [5:0] code;
   for (int k = 0; k < 2 * UNKNOWN_DRAWS; k++)
   begin
      run_and_check(op_instr(I_OPS[k % 10]));   // Nonzero word in between
      if (k < UNKNOWN_DRAWS)
      begin
         do
            code = 6'($urandom_range(63, 0));
         while (opcode_listed(code));
         run_and_check(op_instr(code));
      end
      else
      begin
         do
            code = 6'($urandom_range(63, 0));
         while (funct_listed(code));
         run_and_check(r_instr(code));
      end
      check_alu_ctrl("o_ctrl.alu_ctrl", o_ctrl.alu_ctrl, mips_control_pkg::ALU_CTRL_ADD);
   end
endtask

task automatic stall_holds_word();
   mips_control_pkg::instr_t     held;
   mips_control_pkg::instr_t     next;
   mips_control_pkg::ctrl_word_t held_ctrl;
   int                           stall_cycles;
   for (int round = 0; round < STALL_ROUNDS; round++)
   begin
      held = (round % 2 == 0) ? r_instr(R_FUNCTS[$urandom_range(14, 0)])
                              : op_instr(M_OPS[$urandom_range(8, 0)]);
      next = (round % 2 == 0) ? op_instr(M_OPS[$urandom_range(8, 0)])
                              : r_instr(R_FUNCTS[$urandom_range(12, 0)]);
      run_and_check(held);
      held_ctrl    = expected_ctrl(held);
      stall_cycles = $urandom_range(MAX_STALL, 1);
      repeat (stall_cycles)
      begin
         @(posedge i_clock);
         i_instruction <= rand_instr();   // Must not reach o_ctrl
         @(negedge i_clock);
         check_ctrl("o_ctrl during stall", o_ctrl, held_ctrl);
      end
      run_and_check(next);
   end
endtask

/* bench/mips_control_tb.sv */
`timescale 1ns/1ps

module mips_control_tb;

   localparam int CLOCK_PERIOD  = 40;
   localparam int RESET_CYCLES  = 16;
   localparam int STALL_ROUNDS  = 6;
   localparam int MAX_STALL     = 8;
   localparam int UNKNOWN_DRAWS = 8;
   localparam int TEST_CYCLES   = RESET_CYCLES + 3 * (15 + 9 + 12 + 4 * UNKNOWN_DRAWS)
                                  + STALL_ROUNDS * (6 + MAX_STALL);
   localparam int WATCHDOG_NS   = 2 * TEST_CYCLES * CLOCK_PERIOD;   // Generous margin

   logic                         i_clock;
   logic                         i_soft_reset;
   logic                         i_enable;
   mips_control_pkg::instr_t     i_instruction;
   mips_control_pkg::ctrl_word_t o_ctrl;

   mips_control_pkg::instr_t     current_instr;   // Last instruction checked
   logic [31:0]                  seed_draw;

   mips_control mips_control_inst
   (
      .i_clock       (i_clock),
      .i_soft_reset  (i_soft_reset),
      .i_enable      (i_enable),
      .i_instruction (i_instruction),
      .o_ctrl        (o_ctrl)
   );

   initial
   begin
      i_clock = 1'b0;
      forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_ctrl(input string name, input mips_control_pkg::ctrl_word_t actual,
                             input mips_control_pkg::ctrl_word_t expected);
      if (actual !== expected)
      begin
         $display("Error: %s = 0x%h, expected 0x%h (instruction 0x%h)",
                  name, actual, expected, current_instr);
         $display("Testbench failed");
         $fatal(1, "Control word mismatch");
      end
   endtask

   task automatic check_alu_ctrl(input string name, input mips_control_pkg::alu_ctrl_e actual,
                                 input mips_control_pkg::alu_ctrl_e expected);
      if (actual !== expected)
      begin
         $display("Error: %s = 0x%h, expected 0x%h (instruction 0x%h)",
                  name, actual, expected, current_instr);
         $display("Testbench failed");
         $fatal(1, "ALU control code mismatch");
      end
   endtask

   `include "mips_control_tests.svh"

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      seed_draw     = $urandom(34);
      current_instr = '0;
      i_soft_reset  <= 1'b0;
      i_enable      <= 1'b0;
      i_instruction <= '0;
      repeat (RESET_CYCLES) @(posedge i_clock);
      i_soft_reset <= 1'b1;
      reset_clears_word();
      r_type_decode();
      loads_and_stores();
      immediates_and_jumps();
      unknown_codes();
      stall_holds_word();
      $display("Testbench passed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Testbench failed");
      $fatal(1, "Timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
   end

endmodule

/* mips_control.f */
+incdir+hw
+incdir+bench
hw/mips_control_pkg.sv
hw/main_decoder.sv
hw/alu_control_stage.sv
hw/mips_control.sv
bench/mips_control_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the control unit testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -j 0 \
   --top-module mips_control_tb -f mips_control.f -o Vmips_control_tb &&
./obj_dir/Vmips_control_tb ||
exit 1
